/* dv/gameControlTb.sv */
`timescale 1ns/10ps

module gameControlTb import gamePkg::*; ();

    //////////////////////////////////////////////////
    // timing and run length
    //////////////////////////////////////////////////

    localparam int ClkPeriod = 100;
    localparam int DriveDelay = 10;
    // one held press plus release and margin
    localparam int PressCycles = DebounceCycles + 6;
    // longest cue plus the quiet window that confirms it ended
    localparam int CueCycles = 4 * 2 * NoteCycles + 2 * NoteCycles;
    // about twenty presses and twenty cues over all tests
    localparam int TestCycles = 20 * (PressCycles + CueCycles);
    localparam int ScreenLimit = 2 * CueCycles;

    logic       clk;
    logic       rst;
    logic       continueBtn;
    logic       startBtn;
    logic       playerDead;
    logic       levelComplete;
    logic [2:0] level;
    logic [2:0] world;
    logic [2:0] lives;
    screenT     screen;
    logic       playerEnable;
    logic       gameReset;
    logic       toneOn;
    logic [2:0] noteCode;

    string      testName;
    int         errCount = 0;
    int         errAtStart = 0;
    int         testsRun = 0;
    int         testsFailed = 0;
    int         resetPulses = 0;
    int         seed = 32'hcd03;
    logic       toneOnQ = 1'b0;
    logic [2:0] notesHeard [$];

    gameControl gameControl_i (
        .clk           (clk),
        .rst           (rst),
        .continueBtn   (continueBtn),
        .startBtn      (startBtn),
        .playerDead    (playerDead),
        .levelComplete (levelComplete),
        .level         (level),
        .world         (world),
        .lives         (lives),
        .screen        (screen),
        .playerEnable  (playerEnable),
        .gameReset     (gameReset),
        .toneOn        (toneOn),
        .noteCode      (noteCode)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // monitors and assertions
    //////////////////////////////////////////////////

    // game reset is a single cycle strobe
    resetOnePulse: assert property (@(posedge clk) disable iff (!rst) gameReset |=> !gameReset)
        else begin
            errCount++;
            $display("gameReset stayed high for two cycles in a row");
        end

    // sampled mid cycle away from both edges
    always @(negedge clk) begin
        if (gameReset) resetPulses++;
        // one entry per note taken as the tone starts
        if (toneOn && !toneOnQ) notesHeard.push_back(noteCode);
        toneOnQ = toneOn;
        if (rst) begin
            enableOnlyInPlay: assert (!playerEnable || screen == playScreen) else begin
                errCount++;
                $display("playerEnable high outside the play screen");
            end
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // advance n edges to the drive point
    task automatic stepCycles(int n);
        repeat (n) begin
            @(posedge clk);
            #(DriveDelay);
        end
    endtask

    task automatic checkVal(string what, int want, int got);
        valueMatch: assert (want == got) else begin
            errCount++;
            $display("FAIL %s %s expected %0d actual %0d", testName, what, want, got);
        end
    endtask

    task automatic beginTest(string name);
        testName   = name;
        errAtStart = errCount;
    endtask

    task automatic endTest();
        testsRun++;
        if (errCount != errAtStart) testsFailed++;
        $display("test %-8s %s, %0d errors", testName,
                 (errCount == errAtStart) ? "ok" : "FAILED", errCount - errAtStart);
    endtask

    // hold long enough to debounce and then release
    task automatic pressButton(bit isStart);
        if (isStart) startBtn = 1'b1;
        else continueBtn = 1'b1;
        stepCycles(DebounceCycles + 4);
        startBtn    = 1'b0;
        continueBtn = 1'b0;
        stepCycles(1);
    endtask

    task automatic idleGap();
        int r;
        r = $random(seed);
        stepCycles(2 + ((r & 32'h7fffffff) % 6));
    endtask

    task automatic waitScreen(screenT want);
        int n;
        n = 0;
        while (screen != want && n < ScreenLimit) begin
            stepCycles(1);
            n++;
        end
        screenReached: assert (screen == want) else begin
            errCount++;
            $display("%s: screen did not reach %s within %0d cycles",
                     testName, want.name(), ScreenLimit);
        end
    endtask

    // silence for two note lengths means the cue has ended
    task automatic waitQuiet();
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < 2 * NoteCycles && n < CueCycles * 2) begin
            stepCycles(1);
            n++;
            if (toneOn) quiet = 0;
            else quiet++;
        end
        soundEnded: assert (quiet >= 2 * NoteCycles) else begin
            errCount++;
            $display("%s: sound kept playing past the longest cue", testName);
        end
    endtask

    // one levelComplete pulse and the screen that follows
    task automatic clearLevel(screenT want, int wantLevel, int wantWorld,
                              bit earlyPress, bit moveOn);
        levelComplete = 1'b1;
        stepCycles(1);
        levelComplete = 1'b0;
        waitScreen(want);
        // counters step one edge after the screen shows
        stepCycles(1);
        checkVal("level", wantLevel, int'(level));
        checkVal("world", wantWorld, int'(world));
        checkVal("toneOn", 1, int'(toneOn));
        if (earlyPress) begin
            // press during the cue must be dropped
            pressButton(1'b0);
            checkVal("screen", int'(want), int'(screen));
        end
        if (moveOn) begin
            waitQuiet();
            pressButton(1'b0);
            waitScreen(playScreen);
        end
    endtask

    task automatic loseLife(int wantLives);
        playerDead = 1'b1;
        stepCycles(2);
        checkVal("lives", wantLives, int'(lives));
        checkVal("playerEnable", 1, int'(playerEnable));
        idleGap();
        // holding the death input costs no further life
        checkVal("lives", wantLives, int'(lives));
        checkVal("playerEnable", 1, int'(playerEnable));
        playerDead = 1'b0;
        stepCycles(2);
        checkVal("screen", int'(playScreen), int'(screen));
    endtask

    //////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////

    initial begin
        #(2 * TestCycles * ClkPeriod);
        $display("watchdog expired during test %s", testName);
        $display("Some tests failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    initial begin
        int r;
        int w;
        int l;
        int base;
        rst           = 1'b0;
        continueBtn   = 1'b0;
        startBtn      = 1'b0;
        playerDead    = 1'b0;
        levelComplete = 1'b0;
        testName      = "init";
        stepCycles(16);
        rst = 1'b1;
        stepCycles(1);

        beginTest("reset");
        checkVal("screen", int'(titleScreen), int'(screen));
        checkVal("level", 1, int'(level));
        checkVal("world", 1, int'(world));
        checkVal("lives", int'(StartLives), int'(lives));
        checkVal("playerEnable", 0, int'(playerEnable));
        checkVal("gameReset", 0, int'(gameReset));
        checkVal("toneOn", 0, int'(toneOn));
        endTest();

        beginTest("start");
        // short glitch, below the debounce run
        r = $random(seed);
        startBtn = 1'b1;
        stepCycles(1 + ((r & 32'h7fffffff) % (DebounceCycles - 2)));
        startBtn = 1'b0;
        stepCycles(DebounceCycles + 4);
        checkVal("screen", int'(titleScreen), int'(screen));
        pressButton(1'b1);
        waitScreen(playScreen);
        checkVal("playerEnable", 1, int'(playerEnable));
        endTest();

        beginTest("levels");
        clearLevel(levelUpScreen, 2, 1, 1'b1, 1'b1);
        idleGap();
        clearLevel(levelUpScreen, 3, 1, 1'b0, 1'b1);
        idleGap();
        // last level of the world
        clearLevel(worldUpScreen, 1, 2, 1'b0, 1'b1);
        endTest();

        beginTest("life");
        loseLife(int'(StartLives) - 1);
        endTest();

        beginTest("lose");
        loseLife(1);
        playerDead = 1'b1;
        waitScreen(loseScreen);
        stepCycles(1);
        playerDead = 1'b0;
        checkVal("lives", 0, int'(lives));
        waitQuiet();
        base = resetPulses;
        pressButton(1'b0);
        waitScreen(titleScreen);
        // clear lands one edge into idle
        stepCycles(1);
        checkVal("gameReset pulses", 1, resetPulses - base);
        checkVal("level", 1, int'(level));
        checkVal("world", 1, int'(world));
        checkVal("lives", int'(StartLives), int'(lives));
        endTest();

        beginTest("win");
        pressButton(1'b1);
        waitScreen(playScreen);
        for (w = 1; w <= int'(WorldCount); w++) begin
            for (l = 1; l <= int'(LevelCount); l++) begin
                if (l < int'(LevelCount)) begin
                    clearLevel(levelUpScreen, l + 1, w, 1'b0, 1'b1);
                end else if (w < int'(WorldCount)) begin
                    clearLevel(worldUpScreen, 1, w + 1, 1'b0, 1'b1);
                end else begin
                    notesHeard.delete();
                    clearLevel(winScreen, l, w, 1'b0, 1'b0);
                end
            end
        end
        waitQuiet();
        checkVal("note count", 4, notesHeard.size());
        for (l = 0; l < 4 && l < notesHeard.size(); l++) begin
            checkVal($sformatf("note %0d", l), int'(CueNotes[winCue][l]), int'(notesHeard[l]));
        end
        pressButton(1'b0);
        waitScreen(titleScreen);
        endTest();

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* rtl/buttonConditioner.sv */
`timescale 1ns/10ps

module buttonConditioner import gamePkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic continueBtn,
    input  logic startBtn,
    output logic continuePress,
    output logic startPress
);

    // bit 0 continue, bit 1 start
    logic [1:0] btnRaw;
    logic [1:0] pressVec;

    assign btnRaw = {startBtn, continueBtn};

    for (genvar b = 0; b < 2; b++) begin : gBtn
        logic                    sync1;
        logic                    sync2;
        logic [DebounceCntW-1:0] stableCnt;
        logic                    reported;
        logic                    pressQ;
        logic                    pressNext;

        // last stable cycle reached and this hold not yet reported
        assign pressNext = sync2 && !reported &&
                           (stableCnt >= DebounceCntW'(DebounceCycles - 1));

        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                sync1     <= 1'b0;
                sync2     <= 1'b0;
                stableCnt <= '0;
                reported  <= 1'b0;
                pressQ    <= 1'b0;
            end else begin
                // two flop synchronizer
                sync1 <= btnRaw[b];
                sync2 <= sync1;
                // stable-high run length saturating at the debounce limit
                if (!sync2) begin
                    stableCnt <= '0;
                end else if (stableCnt != DebounceCntW'(DebounceCycles)) begin
                    stableCnt <= stableCnt + DebounceCntW'(1);
                end
                // held button reports once and release rearms
                if (!sync2) begin
                    reported <= 1'b0;
                end else if (pressNext) begin
                    reported <= 1'b1;
                end
                pressQ <= pressNext;
            end
        end

        assign pressVec[b] = pressQ;
    end

    assign continuePress = pressVec[0];
    assign startPress    = pressVec[1];

endmodule

/* rtl/gameControl.sv */
`timescale 1ns/10ps

module gameControl import gamePkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       continueBtn,
    input  logic       startBtn,
    input  logic       playerDead,
    input  logic       levelComplete,
    output logic [2:0] level,
    output logic [2:0] world,
    output logic [2:0] lives,
    output screenT     screen,
    output logic       playerEnable,
    output logic       gameReset,
    output logic       toneOn,
    output logic [2:0] noteCode
);

    //////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////

    // conditioned buttons
    logic continuePress;
    logic startPress;
    // counter controls
    logic clearAll;
    logic levelStep;
    logic worldStep;
    logic lifeStep;
    // sound handshake-free strobe and status
    logic cueStart;
    cueT  cue;
    logic soundIdle;

    buttonConditioner buttonConditioner_i (
        .clk           (clk),
        .rst           (rst),
        .continueBtn   (continueBtn),
        .startBtn      (startBtn),
        .continuePress (continuePress),
        .startPress    (startPress)
    );

    progressCounters progressCounters_i (
        .clk       (clk),
        .rst       (rst),
        .clearAll  (clearAll),
        .levelStep (levelStep),
        .worldStep (worldStep),
        .lifeStep  (lifeStep),
        .level     (level),
        .world     (world),
        .lives     (lives)
    );

    gameFsm gameFsm_i (
        .clk           (clk),
        .rst           (rst),
        .continuePress (continuePress),
        .startPress    (startPress),
        .playerDead    (playerDead),
        .levelComplete (levelComplete),
        .soundIdle     (soundIdle),
        .level         (level),
        .world         (world),
        .lives         (lives),
        .clearAll      (clearAll),
        .levelStep     (levelStep),
        .worldStep     (worldStep),
        .lifeStep      (lifeStep),
        .cueStart      (cueStart),
        .cue           (cue),
        .screen        (screen),
        .playerEnable  (playerEnable),
        .gameReset     (gameReset)
    );

    soundSequencer soundSequencer_i (
        .clk       (clk),
        .rst       (rst),
        .cueStart  (cueStart),
        .cue       (cue),
        .soundIdle (soundIdle),
        .toneOn    (toneOn),
        .noteCode  (noteCode)
    );

endmodule

/* rtl/gameFsm.sv */
`timescale 1ns/10ps

module gameFsm import gamePkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       continuePress,
    input  logic       startPress,
    input  logic       playerDead,
    input  logic       levelComplete,
    input  logic       soundIdle,
    input  logic [2:0] level,
    input  logic [2:0] world,
    input  logic [2:0] lives,
    output logic       clearAll,
    output logic       levelStep,
    output logic       worldStep,
    output logic       lifeStep,
    output logic       cueStart,
    output cueT        cue,
    output screenT     screen,
    output logic       playerEnable,
    output logic       gameReset
);

    //////////////////////////////////////////////////
    // state encoding
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        idle      = 4'd0,
        play      = 4'd1,
        levelUp   = 4'd2,
        levelShow = 4'd3,
        worldUp   = 4'd4,
        worldShow = 4'd5,
        lifeLost  = 4'd6,
        lifeWait  = 4'd7,
        winEnter  = 4'd8,
        winShow   = 4'd9,
        loseEnter = 4'd10,
        loseShow  = 4'd11,
        restart   = 4'd12
    } stateT;

    stateT state;
    stateT stateNext;

    // leaving a message screen needs a press and a quiet sequencer
    logic continueOk;

    assign continueOk = continuePress && soundIdle;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= idle;
        end else begin
            state <= stateNext;
        end
    end

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        stateNext = state;
        case (state)
            idle: begin
                if (startPress) stateNext = play;
            end
            play: begin
                // death wins over a completion in the same cycle
                if (playerDead) begin
                    stateNext = (lives > 3'd1) ? lifeLost : loseEnter;
                end else if (levelComplete) begin
                    if (level < LevelCount) begin
                        stateNext = levelUp;
                    end else if (world < WorldCount) begin
                        stateNext = worldUp;
                    end else begin
                        stateNext = winEnter;
                    end
                end
            end
            levelUp:   stateNext = levelShow;
            worldUp:   stateNext = worldShow;
            levelShow: if (continueOk) stateNext = play;
            worldShow: if (continueOk) stateNext = play;
            lifeLost:  stateNext = lifeWait;
            // wait for the player to clear the hazard
            lifeWait:  if (!playerDead) stateNext = play;
            winEnter:  stateNext = winShow;
            loseEnter: stateNext = loseShow;
            winShow:   if (continueOk) stateNext = restart;
            loseShow:  if (continueOk) stateNext = restart;
            restart:   stateNext = idle;
            default:   stateNext = idle;
        endcase
    end

    //////////////////////////////////////////////////
    // outputs, decoded from state only
    //////////////////////////////////////////////////

    always_comb begin
        clearAll     = 1'b0;
        levelStep    = 1'b0;
        worldStep    = 1'b0;
        lifeStep     = 1'b0;
        cue          = noCue;
        screen       = blankScreen;
        playerEnable = 1'b0;
        gameReset    = 1'b0;
        case (state)
            idle: begin
                screen   = titleScreen;
                clearAll = 1'b1;
            end
            play: begin
                screen       = playScreen;
                playerEnable = 1'b1;
            end
            levelUp: begin
                screen    = levelUpScreen;
                levelStep = 1'b1;
                cue       = levelCue;
            end
            levelShow: screen = levelUpScreen;
            worldUp: begin
                screen    = worldUpScreen;
                worldStep = 1'b1;
                cue       = worldCue;
            end
            worldShow: screen = worldUpScreen;
            lifeLost: begin
                // player may still move out of the hazard
                screen       = playScreen;
                playerEnable = 1'b1;
                lifeStep     = 1'b1;
                cue          = lifeCue;
            end
            lifeWait: begin
                screen       = playScreen;
                playerEnable = 1'b1;
            end
            winEnter: begin
                screen = winScreen;
                cue    = winCue;
            end
            winShow: screen = winScreen;
            loseEnter: begin
                // last life goes here
                screen   = loseScreen;
                lifeStep = 1'b1;
                cue      = loseCue;
            end
            loseShow: screen = loseScreen;
            restart:  gameReset = 1'b1;
            default:  screen = blankScreen;
        endcase
    end

    // any cue other than none is a one-cycle start strobe
    assign cueStart = (cue != noCue);

endmodule

/* rtl/gamePkg.sv */
package gamePkg;

    //////////////////////////////////////////////////
    // game limits
    //////////////////////////////////////////////////

    // levels per world, worlds per game
    localparam logic [2:0] LevelCount = 3'd3;
    localparam logic [2:0] WorldCount = 3'd3;
    // lives handed out by a new game
    localparam logic [2:0] StartLives = 3'd3;

    //////////////////////////////////////////////////
    // timing
    //////////////////////////////////////////////////

    // cycles of stable high before a button counts
    localparam int DebounceCycles = 8;
    // tone length, same length for the gap after it
    localparam int NoteCycles = 6;

    // counter widths derived from the timing above
    localparam int DebounceCntW = $clog2(DebounceCycles + 1);
    localparam int NoteCntW = $clog2(NoteCycles);

    //////////////////////////////////////////////////
    // screen and cue codes
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        blankScreen   = 3'd0,
        titleScreen   = 3'd1,
        playScreen    = 3'd2,
        loseScreen    = 3'd3,
        winScreen     = 3'd4,
        levelUpScreen = 3'd5,
        worldUpScreen = 3'd6
    } screenT;

    typedef enum logic [2:0] {
        noCue    = 3'd0,
        levelCue = 3'd1,
        worldCue = 3'd2,
        lifeCue  = 3'd3,
        winCue   = 3'd4,
        loseCue  = 3'd5
    } cueT;

    // notes per cue, indexed by cue code
    localparam logic [2:0] CueLength [0:7] = '{
        3'd0, 3'd2, 3'd2, 3'd2, 3'd4, 3'd4, 3'd0, 3'd0
    };

    // note codes per cue, zero is kept for silence
    localparam logic [2:0] CueNotes [0:7][0:3] = '{
        '{3'd0, 3'd0, 3'd0, 3'd0},
        '{3'd3, 3'd5, 3'd0, 3'd0},
        '{3'd4, 3'd6, 3'd0, 3'd0},
        '{3'd2, 3'd1, 3'd0, 3'd0},
        '{3'd3, 3'd5, 3'd6, 3'd7},
        '{3'd5, 3'd4, 3'd2, 3'd1},
        '{3'd0, 3'd0, 3'd0, 3'd0},
        '{3'd0, 3'd0, 3'd0, 3'd0}
    };

endpackage

/* rtl/progressCounters.sv */
`timescale 1ns/10ps

module progressCounters import gamePkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       clearAll,
    input  logic       levelStep,
    input  logic       worldStep,
    input  logic       lifeStep,
    output logic [2:0] level,
    output logic [2:0] world,
    output logic [2:0] lives
);

    //////////////////////////////////////////////////
    // counter registers
    //////////////////////////////////////////////////

    logic [2:0] levelQ;
    logic [2:0] worldQ;
    logic [2:0] livesQ;

    // priority clearAll, worldStep, levelStep, lifeStep
    // limits are the FSM's job, no wrap handling here
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            levelQ <= 3'd1;
            worldQ <= 3'd1;
            livesQ <= StartLives;
        end else if (clearAll) begin
            // fresh game
            levelQ <= 3'd1;
            worldQ <= 3'd1;
            livesQ <= StartLives;
        end else if (worldStep) begin
            // next world starts at its first level
            worldQ <= worldQ + 3'd1;
            levelQ <= 3'd1;
        end else if (levelStep) begin
            levelQ <= levelQ + 3'd1;
        end else if (lifeStep) begin
            livesQ <= livesQ - 3'd1;
        end
    end

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    // registered values go straight out
    assign level = levelQ;
    assign world = worldQ;
    assign lives = livesQ;

endmodule

/* rtl/soundSequencer.sv */
`timescale 1ns/10ps

module soundSequencer import gamePkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cueStart,
    input  cueT        cue,
    output logic       soundIdle,
    output logic       toneOn,
    output logic [2:0] noteCode
);

    //////////////////////////////////////////////////
    // playback state
    //////////////////////////////////////////////////

    cueT                 curCue;
    logic [1:0]          noteIdx;
    logic [NoteCntW-1:0] phaseCnt;
    // low while the tone sounds, high during the silent gap
    logic                inGap;
    logic                busy;

    logic                phaseEnd;
    logic                lastNote;

    assign phaseEnd = (phaseCnt == NoteCntW'(NoteCycles - 1));
    assign lastNote = ({1'b0, noteIdx} == (CueLength[curCue] - 3'd1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            curCue   <= noCue;
            noteIdx  <= 2'd0;
            phaseCnt <= '0;
            inGap    <= 1'b0;
            busy     <= 1'b0;
        end else if (cueStart) begin
            // new cue restarts from its first note
            curCue   <= cue;
            noteIdx  <= 2'd0;
            phaseCnt <= '0;
            inGap    <= 1'b0;
            busy     <= (cue != noCue);
        end else if (busy) begin
            if (phaseEnd) begin
                phaseCnt <= '0;
                if (!inGap) begin
                    // tone done so the gap begins
                    inGap <= 1'b1;
                end else begin
                    inGap <= 1'b0;
                    // gap after last note ends the cue
                    if (lastNote) begin
                        busy <= 1'b0;
                    end else begin
                        noteIdx <= noteIdx + 2'd1;
                    end
                end
            end else begin
                phaseCnt <= phaseCnt + NoteCntW'(1);
            end
        end
    end

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    assign soundIdle = !busy;
    assign toneOn    = busy && !inGap;
    // note code only while sounding
    assign noteCode  = toneOn ? CueNotes[curCue][noteIdx] : 3'd0;

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the game controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module gameControlTb -o gameControlSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "verilator build failed with status $buildStatus"
    exit 1
fi

simOut=$(./obj_dir/gameControlSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

# result comes from the testbench's own summary
if grep -q "All tests passed" <<< "$simOut"; then
    exit 0
else
    exit 1
fi

/* vlog.f */
rtl/gamePkg.sv
rtl/buttonConditioner.sv
rtl/progressCounters.sv
rtl/gameFsm.sv
rtl/soundSequencer.sv
rtl/gameControl.sv
dv/gameControlTb.sv
